/* src/icache_pkg.sv */
////////////////////////////////////////////////////////////
// shared definitions for the set-associative instruction cache
// fixed widths, default geometry, port structs and the
// controller state encoding used by all cache blocks
////////////////////////////////////////////////////////////

package icache_pkg;

  // fetch side and physical address width
  localparam int unsigned ADDR_W   = 32;
  // one instruction word
  localparam int unsigned FETCH_W  = 32;
  // one cache line is four words
  localparam int unsigned LINE_W   = 128;
  // byte offset inside a line
  localparam int unsigned OFFSET_W = 4;

  // default geometry, both powers of two
  localparam int unsigned DEFAULT_NUM_WAYS = 4;
  localparam int unsigned DEFAULT_NUM_SETS = 16;

  // fetch unit request
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] vaddr;
  } fetch_req_t;

  // response to the fetch unit, valid for one cycle only
  typedef struct packed {
    logic               valid;
    logic [ADDR_W-1:0]  vaddr;
    logic [FETCH_W-1:0] data;
  } fetch_rsp_t;

  // line or word request towards memory
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [7:0]        way;
  } mem_req_t;

  // refill data, always a full line
  typedef struct packed {
    logic [LINE_W-1:0] data;
  } mem_rtrn_t;

  // controller states
  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

endpackage

/* src/icache_ctrl.sv */
////////////////////////////////////////////////////////////
// instruction cache controller
// captures fetch requests, runs the FLUSH/IDLE/READ/MISS FSM,
// tracks enable and pending flushes, and drives the array
// control and the memory request towards the refill port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl #(
  parameter int unsigned NumWays = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NumSets = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   en_i,
  input  logic                                   flush_i,
  input  icache_pkg::fetch_req_t                 fetch_req_i,
  output logic                                   fetch_ready_o,
  output icache_pkg::fetch_rsp_t                 fetch_rsp_o,
  output logic                                   mem_req_valid_o,
  output icache_pkg::mem_req_t                   mem_req_o,
  input  logic                                   mem_ack_i,
  input  logic                                   mem_rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t                  mem_rtrn_i,
  output logic                                   miss_o,
  output logic                                   busy_o,
  output logic                                   rd_en_o,
  output logic                                   wr_en_o,
  output logic                                   flush_en_o,
  output logic                                   cmp_en_o,
  output logic [$clog2(NumSets)-1:0]             index_o,
  output logic [$clog2(NumSets)-1:0]             flush_idx_o,
  output logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-$clog2(NumSets)-1:0] tag_o,
  output logic [icache_pkg::OFFSET_W-3:0]        offset_o,
  input  logic                                   hit_i,
  input  logic [icache_pkg::FETCH_W-1:0]         hit_data_i,
  input  logic [$clog2(NumWays)-1:0]             repl_way_i
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - OFFSET_W - IdxW;

  ctrl_state_e        state_d, state_q;
  // cache is enabled and flushed
  logic               cache_en_d, cache_en_q;
  // flush request waiting for the next IDLE
  logic               flush_d, flush_q;
  // tag compare in the cycle after a lookup
  logic               cmp_en_d, cmp_en_q;
  // accepted fetch is non-cacheable
  logic               nc_q;
  logic [IdxW-1:0]    flush_cnt_q;
  logic               flush_done;
  logic               rsp_valid;
  logic [ADDR_W-1:0]  vaddr_d, vaddr_q;
  logic [FETCH_W-1:0] rtrn_word;

  //////////////////////////////////////////////////////////
  // address split and port plumbing
  //////////////////////////////////////////////////////////

  // arrays are read at the index of the address being taken
  assign vaddr_d     = rd_en_o ? fetch_req_i.vaddr : vaddr_q;
  assign index_o     = vaddr_d[OFFSET_W +: IdxW];
  assign tag_o       = vaddr_q[ADDR_W-1 -: TagW];
  assign offset_o    = vaddr_q[OFFSET_W-1:2];
  assign cmp_en_o    = cmp_en_q;
  assign flush_idx_o = flush_cnt_q;
  assign flush_done  = (flush_cnt_q == IdxW'(NumSets - 1));
  assign busy_o      = (state_q != IDLE);

  // word-aligned for nc reads, line-aligned for refills
  assign mem_req_o.paddr = nc_q ? {vaddr_q[ADDR_W-1:2], 2'b00} :
                                  {vaddr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_req_o.nc    = nc_q;
  assign mem_req_o.way   = 8'(repl_way_i);

  // nc returns replicate the word, so the offset pick works for both
  assign rtrn_word         = mem_rtrn_i.data[offset_o*FETCH_W +: FETCH_W];
  assign fetch_rsp_o.valid = rsp_valid;
  assign fetch_rsp_o.vaddr = vaddr_q;
  assign fetch_rsp_o.data  = cmp_en_q ? hit_data_i : rtrn_word;

  //////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    // disabling is immediate, enabling goes through FLUSH
    cache_en_d      = cache_en_q & en_i;
    flush_d         = flush_q | flush_i;
    cmp_en_d        = 1'b0;
    fetch_ready_o   = 1'b0;
    rd_en_o         = 1'b0;
    wr_en_o         = 1'b0;
    flush_en_o      = 1'b0;
    mem_req_valid_o = 1'b0;
    miss_o          = 1'b0;
    rsp_valid       = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
        end
      end
      // hit answers here, anything else becomes a memory request
      READ: begin
        if (hit_i) begin
          rsp_valid     = 1'b1;
          state_d       = IDLE;
          fetch_ready_o = !flush_d;
        end else begin
          mem_req_valid_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = !nc_q;
            state_d = MISS;
          end
        end
      end
      // return must be taken in the cycle it shows up
      MISS: begin
        if (mem_rtrn_valid_i) begin
          rsp_valid = 1'b1;
          wr_en_o   = !nc_q;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    // new lookup, also back-to-back after a hit
    if (fetch_ready_o && fetch_req_i.req) begin
      rd_en_o  = 1'b1;
      cmp_en_d = cache_en_q;
      state_d  = READ;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      nc_q        <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      cmp_en_q   <= cmp_en_d;
      // nc is fixed per request so the memory request stays stable
      if (rd_en_o) begin
        nc_q <= !cache_en_q;
      end
      if (flush_en_o) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_addr
    vaddr_q <= vaddr_d;
  end

endmodule

/* src/icache_ways.sv */
////////////////////////////////////////////////////////////
// tag, valid and data arrays of the instruction cache
// one read port shared by all ways with a latency of one
// cycle, a refill write into one way and a per-set flush
// tag compare picks the lowest hitting way and its word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ways #(
  parameter int unsigned NumWays = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NumSets = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   rd_en_i,
  input  logic                                   wr_en_i,
  input  logic                                   flush_en_i,
  input  logic                                   cmp_en_i,
  input  logic [$clog2(NumSets)-1:0]             index_i,
  input  logic [$clog2(NumSets)-1:0]             flush_idx_i,
  input  logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-$clog2(NumSets)-1:0] tag_i,
  input  logic [icache_pkg::OFFSET_W-3:0]        offset_i,
  input  logic [NumWays-1:0]                     way_oh_i,
  input  icache_pkg::mem_rtrn_t                  line_i,
  output logic                                   hit_o,
  output logic [icache_pkg::FETCH_W-1:0]         hit_data_o,
  output logic [NumWays-1:0]                     valid_bits_o
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - OFFSET_W - IdxW;
  localparam int unsigned WayW = $clog2(NumWays);

  // storage
  logic [TagW-1:0]    tag_mem  [NumWays][NumSets];
  logic [LINE_W-1:0]  data_mem [NumWays][NumSets];
  logic [NumWays-1:0] valid_q  [NumSets];

  // registered read port
  logic [TagW-1:0]    tag_rd   [NumWays];
  logic [LINE_W-1:0]  data_rd  [NumWays];
  logic [NumWays-1:0] valid_rd;

  logic [NumWays-1:0] hit_way;
  logic [WayW-1:0]    hit_idx;

  //////////////////////////////////////////////////////////
  // arrays
  //////////////////////////////////////////////////////////

  // write only the chosen way, read all ways together
  always_ff @(posedge clk_i) begin : p_arrays
    for (int w = 0; w < NumWays; w++) begin
      if (wr_en_i && way_oh_i[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        data_mem[w][index_i] <= line_i.data;
      end
      if (rd_en_i) begin
        tag_rd[w]  <= tag_mem[w][index_i];
        data_rd[w] <= data_mem[w][index_i];
      end
    end
  end

  // flush wins over a refill, they never meet in practice
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q  <= '{default: '0};
      valid_rd <= '0;
    end else begin
      if (flush_en_i) begin
        valid_q[flush_idx_i] <= '0;
      end else if (wr_en_i) begin
        valid_q[index_i] <= valid_q[index_i] | way_oh_i;
      end
      if (rd_en_i) begin
        valid_rd <= valid_q[index_i];
      end
    end
  end

  //////////////////////////////////////////////////////////
  // compare and word select
  //////////////////////////////////////////////////////////

  // walk downwards so the lowest hitting way is kept
  always_comb begin : p_hit
    hit_way = '0;
    hit_idx = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      hit_way[w] = cmp_en_i & valid_rd[w] & (tag_rd[w] == tag_i);
      if (hit_way[w]) begin
        hit_idx = WayW'(w);
      end
    end
  end

  assign hit_o        = |hit_way;
  assign hit_data_o   = data_rd[hit_idx][offset_i*FETCH_W +: FETCH_W];
  assign valid_bits_o = valid_rd;

endmodule

/* src/icache_repl.sv */
////////////////////////////////////////////////////////////
// replacement way choice for the instruction cache
// lowest invalid way first, LFSR way once the set is full
// the one-hot pick is held for the later refill write
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_repl #(
  parameter int unsigned NumWays = icache_pkg::DEFAULT_NUM_WAYS
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cmp_en_i,
  input  logic                       wr_en_i,
  input  logic [NumWays-1:0]         valid_bits_i,
  output logic [$clog2(NumWays)-1:0] repl_way_o,
  output logic [NumWays-1:0]         repl_way_oh_o
);

  localparam int unsigned WayW = $clog2(NumWays);
  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  localparam logic [7:0] LfsrTaps = 8'hb8;

  logic [7:0]      lfsr_d, lfsr_q;
  logic [WayW-1:0] inv_way;
  logic            all_valid;

  // first invalid way from the bottom
  always_comb begin : p_inv
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!valid_bits_i[w]) begin
        inv_way = WayW'(w);
      end
    end
  end

  assign all_valid  = &valid_bits_i;
  assign repl_way_o = all_valid ? lfsr_q[WayW-1:0] : inv_way;
  // Galois step, shift right and fold in the taps
  assign lfsr_d     = {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? LfsrTaps : 8'h00);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      lfsr_q        <= 8'h01;
      repl_way_oh_o <= '0;
    end else begin
      // only evictions move the random pointer
      if (wr_en_i && all_valid) begin
        lfsr_q <= lfsr_d;
      end
      if (cmp_en_i) begin
        repl_way_oh_o <= {{(NumWays-1){1'b0}}, 1'b1} << repl_way_o;
      end
    end
  end

endmodule

/* src/icache_top.sv */
////////////////////////////////////////////////////////////
// instruction cache top level
// sits between the fetch unit and a line refill memory
// connects controller, way arrays and replacement logic
// geometry is set here and passed down to all blocks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_top #(
  parameter int unsigned NumWays = icache_pkg::DEFAULT_NUM_WAYS,
  parameter int unsigned NumSets = icache_pkg::DEFAULT_NUM_SETS
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   flush_i,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   fetch_ready_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_ack_i,
  input  logic                   mem_rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t  mem_rtrn_i,
  output logic                   miss_o,
  output logic                   busy_o
);

  import icache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - OFFSET_W - IdxW;
  localparam int unsigned WayW = $clog2(NumWays);

  // array control from the controller
  logic                rd_en, wr_en, flush_en, cmp_en;
  logic [IdxW-1:0]     index, flush_idx;
  logic [TagW-1:0]     tag;
  logic [OFFSET_W-3:0] offset;
  // lookup results
  logic                hit;
  logic [FETCH_W-1:0]  hit_data;
  logic [NumWays-1:0]  valid_bits;
  // replacement choice
  logic [WayW-1:0]     repl_way;
  logic [NumWays-1:0]  repl_way_oh;

  icache_ctrl #(.NumWays(NumWays), .NumSets(NumSets)) i_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i, .fetch_req_i, .fetch_ready_o, .fetch_rsp_o,
    .mem_req_valid_o, .mem_req_o, .mem_ack_i, .mem_rtrn_valid_i, .mem_rtrn_i,
    .miss_o, .busy_o,
    .rd_en_o(rd_en), .wr_en_o(wr_en), .flush_en_o(flush_en), .cmp_en_o(cmp_en),
    .index_o(index), .flush_idx_o(flush_idx), .tag_o(tag), .offset_o(offset),
    .hit_i(hit), .hit_data_i(hit_data), .repl_way_i(repl_way)
  );

  icache_ways #(.NumWays(NumWays), .NumSets(NumSets)) i_ways (
    .clk_i, .rst_ni,
    .rd_en_i(rd_en), .wr_en_i(wr_en), .flush_en_i(flush_en), .cmp_en_i(cmp_en),
    .index_i(index), .flush_idx_i(flush_idx), .tag_i(tag), .offset_i(offset),
    .way_oh_i(repl_way_oh), .line_i(mem_rtrn_i),
    .hit_o(hit), .hit_data_o(hit_data), .valid_bits_o(valid_bits)
  );

  icache_repl #(.NumWays(NumWays)) i_repl (
    .clk_i, .rst_ni, .cmp_en_i(cmp_en), .wr_en_i(wr_en), .valid_bits_i(valid_bits),
    .repl_way_o(repl_way), .repl_way_oh_o(repl_way_oh)
  );

endmodule

/* test/tb_clk_gen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
// free running clock, active low reset held for a few
// rising edges and released on an edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release lines up with a rising edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* test/icache_props.sv */
////////////////////////////////////////////////////////////
// protocol properties of the cache controller
// bound into every controller instance and checked on
// each rising clock edge outside reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input icache_pkg::ctrl_state_e state_i,
  input icache_pkg::fetch_rsp_t  fetch_rsp_i,
  input logic                    mem_req_valid_i,
  input icache_pkg::mem_req_t    mem_req_i,
  input logic                    mem_ack_i,
  input logic                    miss_i
);

  import icache_pkg::*;

  // number of property failures so far
  int unsigned fail_cnt = 0;

  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$isunknown(state_i) && (state_i inside {FLUSH, IDLE, READ, MISS}))
    else begin
      $error("controller state is unknown or illegal");
      fail_cnt++;
    end

  // idle never talks to memory
  no_req_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i == IDLE) |-> !mem_req_valid_i)
    else begin
      $error("memory request raised while the controller is idle");
      fail_cnt++;
    end

  rsp_or_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(fetch_rsp_i.valid && mem_req_valid_i))
    else begin
      $error("fetch response and memory request high together");
      fail_cnt++;
    end

  // a miss is counted only when memory takes a cacheable request
  miss_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
      miss_i |-> (mem_ack_i && !mem_req_i.nc))
    else begin
      $error("miss pulse without an acknowledged cacheable request");
      fail_cnt++;
    end

endmodule

bind icache_ctrl icache_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .state_i        (state_q),
  .fetch_rsp_i    (fetch_rsp_o),
  .mem_req_valid_i(mem_req_valid_o),
  .mem_req_i      (mem_req_o),
  .mem_ack_i      (mem_ack_i),
  .miss_i         (miss_o)
);

/* test/tb_icache.sv */
////////////////////////////////////////////////////////////
// directed testbench for the instruction cache
// a line memory model with random handshake delays serves
// the refills, each test drives fetches and checks data,
// memory traffic and miss pulses against the word rule
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_icache;

  import icache_pkg::*;

  localparam int unsigned NumWays = DEFAULT_NUM_WAYS;
  localparam int unsigned NumSets = DEFAULT_NUM_SETS;
  localparam int          Timeout = 200;
  // line in set 4, used by most tests
  localparam logic [31:0] LineA   = 32'h0000_2040;

  typedef enum logic [2:0] {M_IDLE, M_ACK_WAIT, M_ACK, M_RTRN_WAIT, M_RTRN} mem_phase_e;

  logic       clk;
  logic       rst_n;
  logic       en;
  logic       flush;
  fetch_req_t fetch_req;
  logic       fetch_ready;
  fetch_rsp_t fetch_rsp;
  logic       mem_req_valid;
  mem_req_t   mem_req;
  logic       mem_ack;
  logic       mem_rtrn_valid;
  mem_rtrn_t  mem_rtrn;
  logic       miss;
  logic       busy;

  // memory model state and traffic log
  mem_phase_e mem_phase = M_IDLE;
  int         mem_cnt;
  mem_req_t   pending;
  mem_req_t   req_log[$];
  int         miss_cnt = 0;

  logic [31:0] lcg_state = 32'hf8ced7ea;
  int          n_checks  = 0;
  int          n_errors  = 0;

  tb_clk_gen #(.PeriodNs(100), .ResetCycles(3)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  icache_top UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .en_i            (en),
    .flush_i         (flush),
    .fetch_req_i     (fetch_req),
    .fetch_ready_o   (fetch_ready),
    .fetch_rsp_o     (fetch_rsp),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_ack_i       (mem_ack),
    .mem_rtrn_valid_i(mem_rtrn_valid),
    .mem_rtrn_i      (mem_rtrn),
    .miss_o          (miss),
    .busy_o          (busy)
  );

  //////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // memory content rule
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a5a5a;
  endfunction

  function automatic logic [LINE_W-1:0] refill_line(input mem_req_t r);
    logic [LINE_W-1:0] line;
    for (int w = 0; w < LINE_W / FETCH_W; w++) begin
      // nc reads repeat one word in every slot
      line[w*FETCH_W +: FETCH_W] = r.nc ? mem_word(r.paddr) :
                                          mem_word(r.paddr + 32'(4 * w));
    end
    return line;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    n_checks++;
    assert (cond) else begin
      n_errors++;
      $display("Error: %s", what);
    end
  endtask

  task automatic finish_run();
    int unsigned prop_fails;
    prop_fails = UUT.i_ctrl.u_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, prop_fails);
    if (n_errors == 0 && prop_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout: %s", what);
    finish_run();
  endtask

  // issue count fetches from first on, word by word, back-to-back
  task automatic run_fetches(input logic [31:0] first, input int count, output int cycles);
    logic [31:0] exp_q[$];
    logic [31:0] exp_addr;
    int          sent;
    int          got;
    sent   = 0;
    got    = 0;
    cycles = 0;
    fetch_req <= '{req: 1'b1, vaddr: first};
    while (got < count) begin
      @(posedge clk);
      cycles++;
      // answer first, it belongs to an earlier acceptance
      if (fetch_rsp.valid) begin
        expect_true(exp_q.size() != 0, "fetch response without an accepted request");
        if (exp_q.size() != 0) begin
          exp_addr = exp_q.pop_front();
          compare_word("fetch_rsp_o.vaddr", fetch_rsp.vaddr, exp_addr);
          compare_word("fetch_rsp_o.data", fetch_rsp.data, mem_word(exp_addr));
        end
        got++;
      end
      if (fetch_ready && fetch_req.req) begin
        exp_q.push_back(fetch_req.vaddr);
        sent++;
        if (sent < count) begin
          fetch_req.vaddr <= first + 32'(4 * sent);
        end else begin
          fetch_req.req <= 1'b0;
        end
      end
      if (cycles > Timeout) begin
        report_timeout("no fetch response arrived");
      end
    end
  endtask

  //////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////

  always @(posedge clk) begin : mem_model
    if (miss) begin
      miss_cnt++;
    end
    case (mem_phase)
      M_IDLE: begin
        if (mem_req_valid) begin
          mem_cnt   = int'(lcg_next() >> 30);
          mem_phase = M_ACK_WAIT;
        end
      end
      // ack is high at this edge, so the request is taken now
      M_ACK: begin
        expect_true(mem_req_valid, "memory request dropped before its acknowledge");
        mem_ack <= 1'b0;
        pending = mem_req;
        req_log.push_back(mem_req);
        mem_cnt   = int'(lcg_next() >> 30);
        mem_phase = M_RTRN_WAIT;
      end
      M_RTRN: begin
        mem_rtrn_valid <= 1'b0;
        mem_phase = M_IDLE;
      end
      default: begin
      end
    endcase
    // countdowns fire when they reach zero
    if (mem_phase == M_ACK_WAIT) begin
      if (mem_cnt == 0) begin
        mem_ack <= 1'b1;
        mem_phase = M_ACK;
      end else begin
        mem_cnt--;
      end
    end else if (mem_phase == M_RTRN_WAIT) begin
      if (mem_cnt == 0) begin
        mem_rtrn_valid <= 1'b1;
        mem_rtrn       <= '{data: refill_line(pending)};
        mem_phase = M_RTRN;
      end else begin
        mem_cnt--;
      end
    end
  end

  //////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////

  task automatic test_reset_flush();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 10) begin
        report_timeout("reset was never released");
      end
    end
    cycles = 0;
    while (busy !== 1'b0 || fetch_ready !== 1'b1) begin
      @(posedge clk);
      cycles++;
      expect_true(!mem_req_valid, "memory request issued during the reset flush");
      if (cycles > NumSets + 10) begin
        report_timeout("cache stayed busy after the reset flush");
      end
    end
  endtask

  // unaligned fetch, the refill must still be line-aligned
  task automatic test_cold_miss();
    int cycles;
    req_log.delete();
    miss_cnt = 0;
    run_fetches(LineA + 12, 1, cycles);
    compare_word("memory requests", req_log.size(), 1);
    if (req_log.size() == 1) begin
      compare_word("mem_req_o.paddr", req_log[0].paddr, LineA);
      compare_word("mem_req_o.nc", 32'(req_log[0].nc), 32'h0);
    end
    compare_word("miss_o pulses", miss_cnt, 1);
  endtask

  task automatic test_hits();
    int cycles;
    req_log.delete();
    miss_cnt = 0;
    run_fetches(LineA, 3, cycles);
    compare_word("memory requests", req_log.size(), 0);
    compare_word("miss_o pulses", miss_cnt, 0);
    expect_true(cycles == 4, "hits were not answered back-to-back");
  endtask

  task automatic test_disabled();
    int cycles;
    en <= 1'b0;
    // one edge for the controller to see the cache disabled
    @(posedge clk);
    req_log.delete();
    miss_cnt = 0;
    run_fetches(LineA + 8, 1, cycles);
    run_fetches(LineA + 8, 1, cycles);
    compare_word("memory requests", req_log.size(), 2);
    foreach (req_log[i]) begin
      compare_word("mem_req_o.paddr", req_log[i].paddr, LineA + 8);
      compare_word("mem_req_o.nc", 32'(req_log[i].nc), 32'h1);
    end
    compare_word("miss_o pulses", miss_cnt, 0);
    // enabling flushes, so the cached line misses again
    en <= 1'b1;
    req_log.delete();
    run_fetches(LineA + 4, 1, cycles);
    compare_word("memory requests", req_log.size(), 1);
    compare_word("miss_o pulses", miss_cnt, 1);
  endtask

  task automatic test_flush();
    int cycles;
    req_log.delete();
    miss_cnt = 0;
    run_fetches(LineA + 8, 1, cycles);
    compare_word("memory requests", req_log.size(), 0);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    run_fetches(LineA + 8, 1, cycles);
    compare_word("memory requests", req_log.size(), 1);
    compare_word("miss_o pulses", miss_cnt, 1);
  endtask

  // fill set 9 with random tags, then evict with one more line
  task automatic test_replacement();
    logic [31:0] rnd;
    logic [31:0] lines [NumWays+1];
    int          evict_way;
    int          cycles;
    evict_way = NumWays;
    for (int i = 0; i <= NumWays; i++) begin
      rnd      = lcg_next();
      // bits 11:8 keep the tags distinct
      lines[i] = {rnd[31:12], 4'(i), 4'd9, rnd[3:2], 2'b00};
      req_log.delete();
      run_fetches(lines[i], 1, cycles);
      compare_word("memory requests", req_log.size(), 1);
      if (req_log.size() == 1 && i < NumWays) begin
        compare_word("mem_req_o.way", 32'(req_log[0].way), i);
      end else if (req_log.size() == 1) begin
        evict_way = int'(req_log[0].way);
      end
    end
    expect_true(evict_way < NumWays, "replacement way is out of range");
    // evicting line must now hit in the way it was written to
    req_log.delete();
    run_fetches(lines[NumWays], 1, cycles);
    compare_word("memory requests", req_log.size(), 0);
    if (evict_way < NumWays) begin
      // a neighbour survives, the replaced line has to be refilled
      req_log.delete();
      run_fetches(lines[(evict_way + 1) % NumWays], 1, cycles);
      compare_word("memory requests", req_log.size(), 0);
      req_log.delete();
      run_fetches(lines[evict_way], 1, cycles);
      compare_word("memory requests", req_log.size(), 1);
    end
  endtask

  initial begin : main
    fetch_req      = '0;
    en             = 1'b1;
    flush          = 1'b0;
    mem_ack        = 1'b0;
    mem_rtrn_valid = 1'b0;
    mem_rtrn       = '0;
    test_reset_flush();
    test_cold_miss();
    test_hits();
    test_disabled();
    test_flush();
    test_replacement();
    finish_run();
  end

endmodule

/* compile.f */
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_ways.sv
src/icache_repl.sv
src/icache_top.sv
test/tb_clk_gen.sv
test/icache_props.sv
test/tb_icache.sv
